//--- phy_sop.f
verilog/phy_sop_pkg.sv
verilog/phy_sop_symbol_if.sv
verilog/phy_sop_framer.sv
verilog/phy_sop_kcode_match.sv
verilog/phy_sop_payload_decode.sv
verilog/phy_sop.sv
verif/phy_sop_assert.sv
verif/phy_sop_tb.sv

//--- verif/phy_sop_tb.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop_tb;
    import phy_sop_pkg::*;

    typedef symbol_t oset_t [4];

    localparam int ev_type    = 0;
    localparam int ev_nibble  = 1;
    localparam int ev_eop     = 2;
    localparam int ev_error   = 3;
    localparam int ev_timeout = 4;

    // 12 headers, 35 payload symbols, 2 stray bits before the mid-packet clr
    localparam int total_bits  = 12 * (PREAMBLE_BITS + 20) + 35 * 5 + 2;
    localparam int cycle_limit = 3 * total_bits + 70 * 2 + 500;

    logic      clk;
    logic      rst_n;
    logic      clr;
    logic      bit_in;
    logic      bit_valid;
    sop_type_t sop_type;
    logic      sop_type_valid;
    nibble_t   payload;
    logic      payload_valid;
    logic      eop;
    logic      payload_error;
    logic      timeout;

    logic [15:0] lfsr = 16'd86;
    int          cycles = 0;
    int          exp_kind [$];
    int          exp_val [$];

    // Indexed by sop_type_t value
    oset_t type_sets [5] = '{
        '{K_SYNC_1, K_SYNC_1, K_SYNC_1, K_SYNC_2},
        '{K_SYNC_1, K_SYNC_1, K_SYNC_3, K_SYNC_3},
        '{K_SYNC_1, K_SYNC_3, K_SYNC_1, K_SYNC_3},
        '{K_RST_1, K_RST_1, K_RST_1, K_RST_2},
        '{K_RST_1, K_SYNC_1, K_RST_1, K_SYNC_3}
    };

    phy_sop #(
        .payload_timeout (64)
    ) phy_sop_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .clr            (clr),
        .bit_in         (bit_in),
        .bit_valid      (bit_valid),
        .sop_type       (sop_type),
        .sop_type_valid (sop_type_valid),
        .payload        (payload),
        .payload_valid  (payload_valid),
        .eop            (eop),
        .payload_error  (payload_error),
        .timeout        (timeout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return r;
    endfunction

    function automatic int hits(input oset_t s, input oset_t e);
        int n;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            if (s[i] == e[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // SOP has the lowest priority
    function automatic sop_type_t ref_type(input oset_t s);
        int order [5];
        order = '{1, 2, 3, 4, 0};
        for (int i = 0; i < 5; i++) begin
            if (hits(s, type_sets[order[i]]) >= 3) begin
                return sop_type_t'(order[i]);
            end
        end
        return sop_none;
    endfunction

    function automatic symbol_t ref_encode(input nibble_t n);
        case (n)
            4'h0: return 5'b11110;
            4'h1: return 5'b01001;
            4'h2: return 5'b10100;
            4'h3: return 5'b10101;
            4'h4: return 5'b01010;
            4'h5: return 5'b01011;
            4'h6: return 5'b01110;
            4'h7: return 5'b01111;
            4'h8: return 5'b10010;
            4'h9: return 5'b10011;
            4'ha: return 5'b10110;
            4'hb: return 5'b10111;
            4'hc: return 5'b11010;
            4'hd: return 5'b11011;
            4'he: return 5'b11100;
            default: return 5'b11101;
        endcase
    endfunction

    function automatic string event_name(input int k);
        case (k)
            ev_type:   return "sop_type";
            ev_nibble: return "nibble";
            ev_eop:    return "eop";
            ev_error:  return "payload_error";
            default:   return "timeout";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic push_event(input int kind, input int val);
        exp_kind.push_back(kind);
        exp_val.push_back(val);
    endtask

    // One bit every third cycle
    task automatic send_bit(input logic b);
        @(posedge clk);
        #1;
        bit_in    = b;
        bit_valid = 1'b1;
        @(posedge clk);
        #1;
        bit_valid = 1'b0;
        @(posedge clk);
    endtask

    task automatic send_symbol(input symbol_t s);
        for (int i = 0; i < 5; i++) begin
            send_bit(s[i]);
        end
    endtask

    task automatic send_header(input oset_t s);
        push_event(ev_type, int'(ref_type(s)));
        for (int i = 0; i < PREAMBLE_BITS; i++) begin
            send_bit(i[0]);
        end
        for (int i = 0; i < 4; i++) begin
            send_symbol(s[i]);
        end
    endtask

    task automatic send_nibbles(input int count);
        nibble_t n;
        for (int i = 0; i < count; i++) begin
            n = nibble_t'(rand_bits(4));
            push_event(ev_nibble, int'(n));
            send_symbol(ref_encode(n));
        end
    endtask

    task automatic send_eop();
        push_event(ev_eop, 0);
        send_symbol(K_EOP);
    endtask

    task automatic pulse_clr();
        @(posedge clk);
        #1;
        clr = 1'b1;
        @(posedge clk);
        #1;
        clr = 1'b0;
    endtask

    task automatic wait_drained(input int max_cycles, input string what);
        int n;
        n = 0;
        while (exp_kind.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        assert (exp_kind.size() == 0) else begin
            $display("No %s within %0d cycles", what, max_cycles);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparing process
    //////////////////////////////////////////////////////////////////////

    task automatic check_event(input int kind, input int val);
        int want_kind;
        int want_val;
        if (exp_kind.size() == 0) begin
            $display("Unexpected %s pulse at %0t ns", event_name(kind), $time);
            stop_run();
        end else begin
            want_kind = exp_kind.pop_front();
            want_val  = exp_val.pop_front();
            assert (kind == want_kind && val == want_val) else begin
                $display("[ERROR] %0t ns: expected %s %0d, got %s %0d", $time,
                         event_name(want_kind), want_val, event_name(kind), val);
                stop_run();
            end
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (sop_type_valid) begin
                check_event(ev_type, int'(sop_type));
            end
            if (payload_valid) begin
                check_event(ev_nibble, int'(payload));
            end
            if (eop) begin
                check_event(ev_eop, 0);
            end
            if (payload_error) begin
                check_event(ev_error, 0);
            end
            if (timeout) begin
                check_event(ev_timeout, 0);
            end
        end
    end

    always @(negedge clk) begin
        assert (!phy_sop_i.assert_i.failed) else begin
            $display("A bound assertion on the DUT outputs failed at %0t ns", $time);
            stop_run();
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles <= cycle_limit) else begin
            $display("Run exceeded the limit of %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        oset_t s;
        int    pos;
        rst_n     = 1'b0;
        clr       = 1'b0;
        bit_in    = 1'b0;
        bit_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Clean SOP packet
        pulse_clr();
        send_header(type_sets[0]);
        send_nibbles(8);
        send_eop();
        wait_drained(20, "SOP packet outputs");

        // One corrupt K-code for each type
        for (int t = 0; t < 5; t++) begin
            s   = type_sets[t];
            pos = rand_bits(2);
            do begin
                s[pos] = symbol_t'(rand_bits(5));
            end while (s[pos] == type_sets[t][pos]);
            pulse_clr();
            send_header(s);
            send_eop();
            wait_drained(20, "corrupt ordered set outputs");
        end

        pulse_clr();
        send_header('{K_SYNC_3, K_SYNC_3, K_SYNC_3, K_SYNC_3});
        send_eop();
        wait_drained(20, "unmatched ordered set outputs");

        // Bad symbol between valid nibbles
        pulse_clr();
        send_header(type_sets[0]);
        send_nibbles(4);
        push_event(ev_error, 0);
        send_symbol(5'b00000);
        send_nibbles(4);
        send_eop();
        wait_drained(20, "payload error outputs");

        //////////////////////////////////////////////////////////////////////
        // Payload gap timeout
        //////////////////////////////////////////////////////////////////////

        pulse_clr();
        send_header(type_sets[1]);
        send_nibbles(2);
        push_event(ev_timeout, 0);
        wait_drained(80, "timeout pulse");
        repeat (70) @(posedge clk);

        // No timer after hard reset
        pulse_clr();
        send_header(type_sets[3]);
        wait_drained(20, "hard reset type");
        repeat (150) @(posedge clk);

        // clr in the middle of a payload
        pulse_clr();
        send_header(type_sets[0]);
        send_nibbles(3);
        wait_drained(20, "nibbles before clr");
        send_bit(1'b1);
        send_bit(1'b0);
        pulse_clr();
        send_header(type_sets[0]);
        send_nibbles(4);
        send_eop();
        wait_drained(20, "packet after clr");

        // Pulse length checks on the last pulses need two more edges
        repeat (2) @(posedge clk);
        #1;

        if (phy_sop_i.assert_i.failed) begin
            $display("A bound assertion on the DUT outputs failed");
            stop_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/phy_sop_assert.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop_assert (
    input wire clk,
    input wire rst_n,
    input wire sop_type_valid,
    input wire payload_valid,
    input wire eop,
    input wire payload_error,
    input wire timeout
);

    // Raised by any failing property, read by the testbench
    logic failed;

    initial begin
        failed = 1'b0;
    end

    property one_cycle(p);
        @(posedge clk) disable iff (!rst_n) p |=> !p;
    endproperty

    type_pulse: assert property (one_cycle(sop_type_valid))
        else begin
            failed = 1'b1;
            $error("sop_type_valid high for more than one cycle");
        end

    payload_pulse: assert property (one_cycle(payload_valid))
        else begin
            failed = 1'b1;
            $error("payload_valid high for more than one cycle");
        end

    eop_pulse: assert property (one_cycle(eop))
        else begin
            failed = 1'b1;
            $error("eop high for more than one cycle");
        end

    error_pulse: assert property (one_cycle(payload_error))
        else begin
            failed = 1'b1;
            $error("payload_error high for more than one cycle");
        end

    timeout_pulse: assert property (one_cycle(timeout))
        else begin
            failed = 1'b1;
            $error("timeout high for more than one cycle");
        end

    // One payload result per symbol
    result_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({payload_valid, eop, payload_error}))
        else begin
            failed = 1'b1;
            $error("payload_valid, eop and payload_error overlap");
        end

    timeout_alone: assert property (@(posedge clk) disable iff (!rst_n)
        !(timeout && payload_valid))
        else begin
            failed = 1'b1;
            $error("timeout together with payload_valid");
        end

endmodule

bind phy_sop phy_sop_assert assert_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .sop_type_valid (sop_type_valid),
    .payload_valid  (payload_valid),
    .eop            (eop),
    .payload_error  (payload_error),
    .timeout        (timeout)
);

`default_nettype wire

//--- verilog/phy_sop.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop #(
    parameter int payload_timeout = 4095
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     clr,
    // From the BMC decoder
    input  wire                     bit_in,
    input  wire                     bit_valid,
    output phy_sop_pkg::sop_type_t  sop_type,
    output logic                    sop_type_valid,
    output phy_sop_pkg::nibble_t    payload,
    output logic                    payload_valid,
    output logic                    eop,
    output logic                    payload_error,
    output logic                    timeout
);

    logic timer_arm;

    phy_sop_symbol_if sym ();

    phy_sop_framer framer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (clr),
        .bit_in    (bit_in),
        .bit_valid (bit_valid),
        .sym       (sym.framer)
    );

    phy_sop_kcode_match kcode_match_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .clr            (clr),
        .sym            (sym.kcode_sink),
        .sop_type       (sop_type),
        .sop_type_valid (sop_type_valid),
        .timer_arm      (timer_arm)
    );

    phy_sop_payload_decode #(
        .payload_timeout (payload_timeout)
    ) payload_decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .clr           (clr),
        .timer_arm     (timer_arm),
        .sym           (sym.payload_sink),
        .payload       (payload),
        .payload_valid (payload_valid),
        .eop           (eop),
        .payload_error (payload_error),
        .timeout       (timeout)
    );

endmodule

`default_nettype wire

//--- verilog/phy_sop_payload_decode.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop_payload_decode #(
    parameter int payload_timeout = 4095
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     clr,
    input  wire                     timer_arm,
    phy_sop_symbol_if.payload_sink  sym,
    output phy_sop_pkg::nibble_t    payload,
    output logic                    payload_valid,
    output logic                    eop,
    output logic                    payload_error,
    output logic                    timeout
);
    import phy_sop_pkg::*;

    localparam int cnt_w = $clog2(payload_timeout + 1);

    logic             take;
    logic             is_eop;
    logic             dec_hit;
    nibble_t          dec_nibble;
    logic             timer_run;
    logic [cnt_w-1:0] timer_cnt;
    logic             expire;

    assign take   = sym.valid && !sym.kcode;
    assign is_eop = (sym.symbol == K_EOP);

    //////////////////////////////////////////////////////////////////////
    // 4b5b decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_hit    = 1'b1;
        dec_nibble = 4'h0;
        case (sym.symbol)
            5'b11110: dec_nibble = 4'h0;
            5'b01001: dec_nibble = 4'h1;
            5'b10100: dec_nibble = 4'h2;
            5'b10101: dec_nibble = 4'h3;
            5'b01010: dec_nibble = 4'h4;
            5'b01011: dec_nibble = 4'h5;
            5'b01110: dec_nibble = 4'h6;
            5'b01111: dec_nibble = 4'h7;
            5'b10010: dec_nibble = 4'h8;
            5'b10011: dec_nibble = 4'h9;
            5'b10110: dec_nibble = 4'ha;
            5'b10111: dec_nibble = 4'hb;
            5'b11010: dec_nibble = 4'hc;
            5'b11011: dec_nibble = 4'hd;
            5'b11100: dec_nibble = 4'he;
            5'b11101: dec_nibble = 4'hf;
            default:  dec_hit    = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            payload_valid <= 1'b0;
            eop           <= 1'b0;
            payload_error <= 1'b0;
            timeout       <= 1'b0;
        end else begin
            payload_valid <= take && dec_hit;
            eop           <= take && is_eop;
            payload_error <= take && !dec_hit && !is_eop;
            // A symbol in the same cycle restarts the gap instead
            timeout       <= expire && !take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            payload <= dec_nibble;
        end
    end

    assign sym.stop = eop;

    //////////////////////////////////////////////////////////////////////
    // Payload gap timer
    //////////////////////////////////////////////////////////////////////

    assign expire = timer_run && (timer_cnt == cnt_w'(payload_timeout));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_run <= 1'b0;
            timer_cnt <= '0;
        end else if (clr) begin
            timer_run <= 1'b0;
            timer_cnt <= '0;
        end else if (timer_arm) begin
            timer_run <= 1'b1;
            timer_cnt <= '0;
        end else if (take) begin
            timer_cnt <= '0;
            if (is_eop) begin
                timer_run <= 1'b0;
            end
        end else if (expire) begin
            timer_run <= 1'b0;
        end else if (timer_run) begin
            timer_cnt <= timer_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/phy_sop_kcode_match.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop_kcode_match (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     clr,
    phy_sop_symbol_if.kcode_sink    sym,
    output phy_sop_pkg::sop_type_t  sop_type,
    output logic                    sop_type_valid,
    output logic                    timer_arm
);
    import phy_sop_pkg::*;

    // Sticky flags, index is the ordered set position
    logic [2:0] s1_hit;
    logic [3:1] s3_hit;
    logic [2:0] r1_hit;
    logic       s2_hit;
    logic       r2_hit;

    logic [2:0] s1_nxt;
    logic [3:1] s3_nxt;
    logic [2:0] r1_nxt;
    logic       s2_nxt;
    logic       r2_nxt;

    logic       take;
    logic       set_done;
    sop_type_t  type_nxt;

    function automatic logic three_of_four(input logic [3:0] v);
        return (v[0] & v[1] & v[2]) | (v[0] & v[1] & v[3]) |
               (v[0] & v[2] & v[3]) | (v[1] & v[2] & v[3]);
    endfunction

    assign take     = sym.valid && sym.kcode;
    assign set_done = take && (sym.idx == 2'd3);

    always_comb begin
        s1_nxt = s1_hit;
        s3_nxt = s3_hit;
        r1_nxt = r1_hit;
        s2_nxt = s2_hit;
        r2_nxt = r2_hit;
        if (take) begin
            if (sym.idx != 2'd3) begin
                s1_nxt[sym.idx] = s1_hit[sym.idx] | (sym.symbol == K_SYNC_1);
                r1_nxt[sym.idx] = r1_hit[sym.idx] | (sym.symbol == K_RST_1);
            end else begin
                s2_nxt = s2_hit | (sym.symbol == K_SYNC_2);
                r2_nxt = r2_hit | (sym.symbol == K_RST_2);
            end
            if (sym.idx != 2'd0) begin
                s3_nxt[sym.idx] = s3_hit[sym.idx] | (sym.symbol == K_SYNC_3);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Ordered set classifier, vectors are {pos3, pos2, pos1, pos0}
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (three_of_four({s3_nxt[3], s3_nxt[2], s1_nxt[1], s1_nxt[0]})) begin
            type_nxt = sop_prime;
        end else if (three_of_four({s3_nxt[3], s1_nxt[2], s3_nxt[1], s1_nxt[0]})) begin
            type_nxt = sop_dprime;
        end else if (three_of_four({r2_nxt, r1_nxt[2], r1_nxt[1], r1_nxt[0]})) begin
            type_nxt = sop_hard_reset;
        end else if (three_of_four({s3_nxt[3], r1_nxt[2], s1_nxt[1], r1_nxt[0]})) begin
            type_nxt = sop_cable_reset;
        end else if (three_of_four({s2_nxt, s1_nxt[2], s1_nxt[1], s1_nxt[0]})) begin
            type_nxt = sop_sop;
        end else begin
            type_nxt = sop_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_hit   <= 3'b000;
            s3_hit   <= 3'b000;
            r1_hit   <= 3'b000;
            s2_hit   <= 1'b0;
            r2_hit   <= 1'b0;
            sop_type <= sop_none;
        end else if (clr) begin
            s1_hit   <= 3'b000;
            s3_hit   <= 3'b000;
            r1_hit   <= 3'b000;
            s2_hit   <= 1'b0;
            r2_hit   <= 1'b0;
            sop_type <= sop_none;
        end else begin
            s1_hit <= s1_nxt;
            s3_hit <= s3_nxt;
            r1_hit <= r1_nxt;
            s2_hit <= s2_nxt;
            r2_hit <= r2_nxt;
            if (set_done) begin
                sop_type <= type_nxt;
            end
        end
    end

    // Reset ordered sets carry no payload, so no gap timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop_type_valid <= 1'b0;
            timer_arm      <= 1'b0;
        end else begin
            sop_type_valid <= set_done;
            timer_arm      <= set_done && (type_nxt != sop_hard_reset) &&
                              (type_nxt != sop_cable_reset);
        end
    end

endmodule

`default_nettype wire

//--- verilog/phy_sop_framer.sv
`timescale 1ns/100ps
`default_nettype none

module phy_sop_framer (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             clr,
    input  wire             bit_in,
    input  wire             bit_valid,
    phy_sop_symbol_if.framer sym
);
    import phy_sop_pkg::*;

    localparam int pre_w = $clog2(PREAMBLE_BITS);

    frame_state_t     state;
    logic [pre_w-1:0] preamble_cnt;
    logic [2:0]       bit_cnt;
    logic [3:0]       shift;
    kcode_idx_t       kidx;
    logic             assembling;
    logic             sym_done;

    assign assembling = (state == st_kcode) || (state == st_payload);
    assign sym_done   = assembling && bit_valid && (bit_cnt == 3'd4);

    //////////////////////////////////////////////////////////////////////
    // Frame phase FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_preamble;
            preamble_cnt <= '0;
            bit_cnt      <= 3'd0;
            kidx         <= 2'd0;
            sym.valid    <= 1'b0;
            sym.kcode    <= 1'b0;
            sym.idx      <= 2'd0;
        end else if (clr) begin
            state        <= st_preamble;
            preamble_cnt <= '0;
            bit_cnt      <= 3'd0;
            kidx         <= 2'd0;
            sym.valid    <= 1'b0;
            sym.kcode    <= 1'b0;
            sym.idx      <= 2'd0;
        end else begin
            sym.valid <= sym_done;
            sym.kcode <= (state == st_kcode);
            sym.idx   <= kidx;
            if (assembling && bit_valid) begin
                bit_cnt <= sym_done ? 3'd0 : bit_cnt + 3'd1;
            end
            case (state)
                st_preamble: begin
                    // Counter wraps back to zero on the last preamble bit
                    if (bit_valid) begin
                        preamble_cnt <= preamble_cnt + 1'b1;
                        if (preamble_cnt == pre_w'(PREAMBLE_BITS - 1)) begin
                            state <= st_kcode;
                        end
                    end
                end
                st_kcode: begin
                    if (sym_done) begin
                        kidx <= kidx + 2'd1;
                        if (kidx == 2'd3) begin
                            state <= st_payload;
                        end
                    end
                end
                st_payload: begin
                    if (sym.stop) begin
                        state <= st_idle;
                    end
                end
                default: ;
            endcase
        end
    end

    // Bits enter at the top, first bit ends in bit 0
    always_ff @(posedge clk) begin
        if (bit_valid) begin
            shift <= {bit_in, shift[3:1]};
        end
        if (sym_done) begin
            sym.symbol <= {bit_in, shift};
        end
    end

endmodule

`default_nettype wire

//--- verilog/phy_sop_symbol_if.sv
`timescale 1ns/100ps
`default_nettype none

interface phy_sop_symbol_if;
    import phy_sop_pkg::*;

    logic       valid;
    symbol_t    symbol;
    logic       kcode;
    kcode_idx_t idx;
    // EOP seen, framer goes idle
    logic       stop;

    modport framer (output valid, output symbol, output kcode, output idx, input stop);

    modport kcode_sink (input valid, input symbol, input kcode, input idx);

    modport payload_sink (input valid, input symbol, input kcode, output stop);

endinterface

`default_nettype wire

//--- verilog/phy_sop_pkg.sv
`default_nettype none

package phy_sop_pkg;

    // Line code and payload widths
    typedef logic [4:0] symbol_t;
    typedef logic [3:0] nibble_t;
    typedef logic [1:0] kcode_idx_t;

    // K-codes, first received bit in bit 0
    localparam symbol_t K_SYNC_1 = 5'b11000;
    localparam symbol_t K_SYNC_2 = 5'b10001;
    localparam symbol_t K_SYNC_3 = 5'b00110;
    localparam symbol_t K_RST_1  = 5'b00111;
    localparam symbol_t K_RST_2  = 5'b11001;
    localparam symbol_t K_EOP    = 5'b01101;

    localparam int PREAMBLE_BITS = 64;

    typedef enum logic [2:0] {
        sop_sop         = 3'd0,
        sop_prime       = 3'd1,
        sop_dprime      = 3'd2,
        sop_hard_reset  = 3'd3,
        sop_cable_reset = 3'd4,
        sop_none        = 3'd7
    } sop_type_t;

    typedef enum logic [1:0] {
        st_preamble,
        st_kcode,
        st_payload,
        st_idle
    } frame_state_t;

endpackage

`default_nettype wire
